/* hdl/conv_engine.sv */
`default_nettype none

module conv_engine #(
	parameter int MUL_TERMS = 3
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            start_i,
	kernel_list_if.eng      list_if,
	window_if.eng           win_if,
	output logic            busy_o,
	output logic            done_o,
	output conv_pkg::kidx_t count_o,
	output conv_pkg::word_t result_o [conv_pkg::RESULT_N]
);

	// pixel split greedily into 7/5/3/1 terms, leftover is dropped
	function automatic conv_pkg::word_t greedy_mul(input conv_pkg::word_t k,
			input conv_pkg::word_t p);
		conv_pkg::word_t rem;
		conv_pkg::word_t acc;
		rem = p;
		acc = '0;
		for (int t = 0; t < MUL_TERMS; t++) begin
			if (rem >= 32'd7) begin
				acc += (k << 2) + (k << 1) + k;
				rem -= 32'd7;
			end else if (rem >= 32'd5) begin
				acc += (k << 2) + k;
				rem -= 32'd5;
			end else if (rem >= 32'd3) begin
				acc += (k << 1) + k;
				rem -= 32'd3;
			end else if (rem >= 32'd1) begin
				acc += k;
				rem -= 32'd1;
			end
		end
		return acc;
	endfunction

	conv_pkg::eng_state_e state_q;
	conv_pkg::kidx_t      idx_q;
	conv_pkg::kidx_t      count_q;
	conv_pkg::word_t      acc_q    [conv_pkg::RESULT_N];
	conv_pkg::word_t      win_pix  [conv_pkg::RESULT_N];
	conv_pkg::word_t      prod     [conv_pkg::RESULT_N];

	// kernel position of the current entry picks the window
	assign list_if.entry_idx = idx_q;
	assign win_if.win_row    = list_if.entry_row;
	assign win_if.win_col    = list_if.entry_col;

	assign win_pix[0] = win_if.pix0;
	assign win_pix[1] = win_if.pix1;
	assign win_pix[2] = win_if.pix2;
	assign win_pix[3] = win_if.pix3;

	always_comb begin
		for (int o = 0; o < conv_pkg::RESULT_N; o++) begin
			prod[o] = greedy_mul(list_if.entry_val, win_pix[o]);
		end
	end

	// ========================================
	// run control
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= conv_pkg::E_IDLE;
			idx_q   <= '0;
			count_q <= '0;
			for (int o = 0; o < conv_pkg::RESULT_N; o++) begin
				acc_q[o] <= '0;
			end
		end else begin
			case (state_q)
				conv_pkg::E_IDLE, conv_pkg::E_DONE: begin
					if (start_i) begin
						state_q <= conv_pkg::E_WAIT_LIST;
						idx_q   <= '0;
						for (int o = 0; o < conv_pkg::RESULT_N; o++) begin
							acc_q[o] <= '0;
						end
					end
				end
				conv_pkg::E_WAIT_LIST: begin
					if (list_if.list_ready) begin
						count_q <= list_if.count;
						if (list_if.count == '0) begin
							state_q <= conv_pkg::E_DONE;
						end else begin
							state_q <= conv_pkg::E_RUN;
						end
					end
				end
				conv_pkg::E_RUN: begin
					for (int o = 0; o < conv_pkg::RESULT_N; o++) begin
						acc_q[o] <= acc_q[o] + prod[o];
					end
					// idx stays inside the list
					if (idx_q == conv_pkg::kidx_t'(count_q - 4'd1)) begin
						state_q <= conv_pkg::E_DONE;
						idx_q   <= '0;
					end else begin
						idx_q <= idx_q + 4'd1;
					end
				end
				default: state_q <= conv_pkg::E_IDLE;
			endcase
		end
	end

	assign busy_o   = (state_q == conv_pkg::E_WAIT_LIST) || (state_q == conv_pkg::E_RUN);
	assign done_o   = (state_q == conv_pkg::E_DONE);
	assign count_o  = count_q;
	assign result_o = acc_q;

endmodule

`default_nettype wire

/* hdl/conv_ifs.sv */
`default_nettype none

// ========================================
// compressed kernel list
// ========================================
interface kernel_list_if;
	logic              list_ready;
	conv_pkg::kidx_t   count;
	conv_pkg::kidx_t   entry_idx;
	conv_pkg::word_t   entry_val;
	conv_pkg::kpos_t   entry_row;
	conv_pkg::kpos_t   entry_col;

	// entry_* follow entry_idx without a register stage
	modport list (
		output list_ready,
		output count,
		output entry_val,
		output entry_row,
		output entry_col,
		input  entry_idx
	);

	modport eng (
		input  list_ready,
		input  count,
		input  entry_val,
		input  entry_row,
		input  entry_col,
		output entry_idx
	);
endinterface

// ========================================
// 2x2 pixel window
// ========================================
interface window_if;
	conv_pkg::kpos_t win_row;
	conv_pkg::kpos_t win_col;
	conv_pkg::word_t pix0;
	conv_pkg::word_t pix1;
	conv_pkg::word_t pix2;
	conv_pkg::word_t pix3;

	modport buffer (input win_row, win_col, output pix0, pix1, pix2, pix3);
	modport eng (output win_row, win_col, input pix0, pix1, pix2, pix3);
endinterface

`default_nettype wire

/* hdl/conv_pkg.sv */
`default_nettype none

package conv_pkg;

	// widths
	typedef logic [31:0] word_t;
	typedef logic [3:0]  kidx_t;
	typedef logic [1:0]  kpos_t;
	typedef logic [5:0]  waddr_t;

	// sizes
	localparam int KERNEL_N = 9;
	localparam int IFMAP_N  = 16;
	localparam int RESULT_N = 4;

	// word address map
	localparam waddr_t KERNEL_BASE = 6'h00;
	localparam waddr_t IFMAP_BASE  = 6'h10;
	localparam waddr_t CTRL_ADDR   = 6'h20;
	localparam waddr_t STATUS_ADDR = 6'h21;
	localparam waddr_t RESULT_BASE = 6'h28;

	// compressor FSM
	typedef enum logic [1:0] {C_IDLE, C_SCAN, C_DONE} comp_state_e;

	// engine FSM
	typedef enum logic [1:0] {E_IDLE, E_WAIT_LIST, E_RUN, E_DONE} eng_state_e;

endpackage

`default_nettype wire

/* hdl/ifmap_buffer.sv */
`default_nettype none

module ifmap_buffer (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            pix_we_i,
	input  logic [3:0]      pix_idx_i,
	input  conv_pkg::word_t pix_dat_i,
	window_if.buffer        win_if
);

	// row-major, four pixels per row
	conv_pkg::word_t pix_mem [conv_pkg::IFMAP_N];
	logic [3:0]      base;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < conv_pkg::IFMAP_N; i++) begin
				pix_mem[i] <= '0;
			end
		end else if (pix_we_i) begin
			pix_mem[pix_idx_i] <= pix_dat_i;
		end
	end

	// row*4 + col, col never exceeds 2
	assign base = {win_if.win_row, win_if.win_col};

	// ========================================
	// window taps
	// ========================================
	assign win_if.pix0 = pix_mem[base];
	assign win_if.pix1 = pix_mem[base + 4'd1];
	assign win_if.pix2 = pix_mem[base + 4'd4];
	assign win_if.pix3 = pix_mem[base + 4'd5];

endmodule

`default_nettype wire

/* hdl/kernel_compressor.sv */
`default_nettype none

module kernel_compressor (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            kern_we_i,
	input  conv_pkg::kidx_t kern_idx_i,
	input  conv_pkg::word_t kern_dat_i,
	input  logic            start_i,
	kernel_list_if.list     list_if
);

	conv_pkg::word_t kern_mem [conv_pkg::KERNEL_N];

	// compressed list, entries below count are valid
	conv_pkg::word_t list_val [conv_pkg::KERNEL_N];
	conv_pkg::kpos_t list_row [conv_pkg::KERNEL_N];
	conv_pkg::kpos_t list_col [conv_pkg::KERNEL_N];

	conv_pkg::comp_state_e state_q;
	conv_pkg::kidx_t       scan_idx;
	conv_pkg::kpos_t       scan_row;
	conv_pkg::kpos_t       scan_col;
	conv_pkg::kidx_t       count_q;
	logic                  ready_q;

	always_ff @(posedge clk) begin
		if (kern_we_i) begin
			kern_mem[kern_idx_i] <= kern_dat_i;
		end
	end

	// ========================================
	// scan, one kernel word per cycle
	// ========================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q  <= conv_pkg::C_IDLE;
			scan_idx <= '0;
			scan_row <= '0;
			scan_col <= '0;
			count_q  <= '0;
			ready_q  <= 1'b0;
		end else if (start_i) begin
			state_q  <= conv_pkg::C_SCAN;
			scan_idx <= '0;
			scan_row <= '0;
			scan_col <= '0;
			count_q  <= '0;
			ready_q  <= 1'b0;
		end else if (state_q == conv_pkg::C_SCAN) begin
			if (kern_mem[scan_idx] != '0) begin
				list_val[count_q] <= kern_mem[scan_idx];
				list_row[count_q] <= scan_row;
				list_col[count_q] <= scan_col;
				count_q           <= count_q + 4'd1;
			end
			// row/col counters replace index/3 and index%3
			if (scan_col == 2'd2) begin
				scan_col <= '0;
				scan_row <= scan_row + 2'd1;
			end else begin
				scan_col <= scan_col + 2'd1;
			end
			if (scan_idx == conv_pkg::kidx_t'(conv_pkg::KERNEL_N - 1)) begin
				state_q <= conv_pkg::C_DONE;
				ready_q <= 1'b1;
			end else begin
				scan_idx <= scan_idx + 4'd1;
			end
		end
	end

	assign list_if.list_ready = ready_q;
	assign list_if.count      = count_q;
	assign list_if.entry_val  = list_val[list_if.entry_idx];
	assign list_if.entry_row  = list_row[list_if.entry_idx];
	assign list_if.entry_col  = list_col[list_if.entry_idx];

endmodule

`default_nettype wire

/* hdl/sparse_conv_top.sv */
`default_nettype none

module sparse_conv_top #(
	parameter int MUL_TERMS = 3
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             wb_cyc_i,
	input  logic             wb_stb_i,
	input  logic             wb_we_i,
	input  conv_pkg::waddr_t wb_adr_i,
	input  conv_pkg::word_t  wb_dat_i,
	output conv_pkg::word_t  wb_dat_o,
	output logic             wb_ack_o
);

	logic            kern_we;
	conv_pkg::kidx_t kern_idx;
	conv_pkg::word_t kern_dat;
	logic            pix_we;
	logic [3:0]      pix_idx;
	conv_pkg::word_t pix_dat;
	logic            start;
	logic            busy;
	logic            done;
	conv_pkg::kidx_t count;
	conv_pkg::word_t result [conv_pkg::RESULT_N];

	kernel_list_if klist_if ();
	window_if      win_if ();

	// ========================================
	// bus slave
	// ========================================
	wb_conv_regs wb_conv_regs_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.wb_we_i    (wb_we_i),
		.wb_adr_i   (wb_adr_i),
		.wb_dat_i   (wb_dat_i),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o),
		.kern_we_o  (kern_we),
		.kern_idx_o (kern_idx),
		.kern_dat_o (kern_dat),
		.pix_we_o   (pix_we),
		.pix_idx_o  (pix_idx),
		.pix_dat_o  (pix_dat),
		.start_o    (start),
		.busy_i     (busy),
		.done_i     (done),
		.count_i    (count),
		.result_i   (result)
	);

	// ========================================
	// datapath
	// ========================================
	kernel_compressor kernel_compressor_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.kern_we_i  (kern_we),
		.kern_idx_i (kern_idx),
		.kern_dat_i (kern_dat),
		.start_i    (start),
		.list_if    (klist_if.list)
	);

	ifmap_buffer ifmap_buffer_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.pix_we_i  (pix_we),
		.pix_idx_i (pix_idx),
		.pix_dat_i (pix_dat),
		.win_if    (win_if.buffer)
	);

	conv_engine #(
		.MUL_TERMS (MUL_TERMS)
	) conv_engine_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.start_i  (start),
		.list_if  (klist_if.eng),
		.win_if   (win_if.eng),
		.busy_o   (busy),
		.done_o   (done),
		.count_o  (count),
		.result_o (result)
	);

endmodule

`default_nettype wire

/* hdl/wb_conv_regs.sv */
`default_nettype none

module wb_conv_regs (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    wb_cyc_i,
	input  logic                    wb_stb_i,
	input  logic                    wb_we_i,
	input  conv_pkg::waddr_t        wb_adr_i,
	input  conv_pkg::word_t         wb_dat_i,
	output conv_pkg::word_t         wb_dat_o,
	output logic                    wb_ack_o,
	output logic                    kern_we_o,
	output conv_pkg::kidx_t         kern_idx_o,
	output conv_pkg::word_t         kern_dat_o,
	output logic                    pix_we_o,
	output logic [3:0]              pix_idx_o,
	output conv_pkg::word_t         pix_dat_o,
	output logic                    start_o,
	input  logic                    busy_i,
	input  logic                    done_i,
	input  conv_pkg::kidx_t         count_i,
	input  conv_pkg::word_t         result_i [conv_pkg::RESULT_N]
);

	logic             access;
	logic             wr_ok;
	conv_pkg::waddr_t kern_off;
	conv_pkg::waddr_t pix_off;
	conv_pkg::waddr_t res_off;
	conv_pkg::word_t  rd_data;

	// new cycle seen, ack goes out on the next edge
	assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;
	assign wr_ok  = access & wb_we_i & ~busy_i;

	assign kern_off = wb_adr_i - conv_pkg::KERNEL_BASE;
	assign pix_off  = wb_adr_i - conv_pkg::IFMAP_BASE;
	assign res_off  = wb_adr_i - conv_pkg::RESULT_BASE;

	// ========================================
	// write strobes, land on the ack edge
	// ========================================
	assign kern_we_o  = wr_ok && (kern_off < conv_pkg::waddr_t'(conv_pkg::KERNEL_N));
	assign kern_idx_o = kern_off[3:0];
	assign kern_dat_o = wb_dat_i;

	assign pix_we_o  = wr_ok && (pix_off < conv_pkg::waddr_t'(conv_pkg::IFMAP_N));
	assign pix_idx_o = pix_off[3:0];
	assign pix_dat_o = wb_dat_i;

	assign start_o = wr_ok && (wb_adr_i == conv_pkg::CTRL_ADDR) && wb_dat_i[0];

	// read mux, anything unmapped reads as zero
	always_comb begin
		rd_data = '0;
		if (wb_adr_i == conv_pkg::STATUS_ADDR) begin
			rd_data[0]   = busy_i;
			rd_data[1]   = done_i;
			rd_data[7:4] = count_i;
		end else if (res_off < conv_pkg::waddr_t'(conv_pkg::RESULT_N)) begin
			rd_data = result_i[res_off[1:0]];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack_o <= 1'b0;
			wb_dat_o <= '0;
		end else begin
			wb_ack_o <= access;
			if (access && !wb_we_i) begin
				wb_dat_o <= rd_data;
			end
		end
	end

endmodule

`default_nettype wire

/* project.f */
hdl/conv_pkg.sv
hdl/conv_ifs.sv
hdl/wb_conv_regs.sv
hdl/kernel_compressor.sv
hdl/ifmap_buffer.sv
hdl/conv_engine.sv
hdl/sparse_conv_top.sv
verification/tb_sparse_conv.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the sparse convolution testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
	-f project.f \
	--top-module tb_sparse_conv \
	--Mdir obj_dir \
	-o tb_sparse_conv

./obj_dir/tb_sparse_conv | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi
echo "simulation finished without failures"

/* verification/tb_sparse_conv.sv */
`default_nettype none

module tb_sparse_conv;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_PERIOD      = 4;
	localparam int MUL_TERMS       = 3;
	localparam int ACK_WAIT        = 4;
	localparam int POLL_LIMIT      = 40;
	localparam int TEST_COUNT      = 6;
	localparam int CYCLES_PER_TEST = 400;
	localparam int MARGIN_CYCLES   = 200;

	// greedy terms, largest first
	localparam conv_pkg::word_t TERMS [4] = '{32'd7, 32'd5, 32'd3, 32'd1};

	logic             clk;
	logic             rst_n;
	logic             wb_cyc;
	logic             wb_stb;
	logic             wb_we;
	conv_pkg::waddr_t wb_adr;
	conv_pkg::word_t  wb_dat;
	conv_pkg::word_t  wb_dat_o;
	logic             wb_ack_o;

	conv_pkg::word_t kern    [conv_pkg::KERNEL_N];
	conv_pkg::word_t pix     [conv_pkg::IFMAP_N];
	conv_pkg::word_t exp_res [conv_pkg::RESULT_N];
	int              exp_count;
	conv_pkg::word_t lcg_state;
	int              checks;
	int              errors;

	sparse_conv_top #(
		.MUL_TERMS (MUL_TERMS)
	) sparse_conv_top_i (
		.clk      (clk),
		.rst_n    (rst_n),
		.wb_cyc_i (wb_cyc),
		.wb_stb_i (wb_stb),
		.wb_we_i  (wb_we),
		.wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(CLK_PERIOD * (TEST_COUNT * CYCLES_PER_TEST + MARGIN_CYCLES));
		$display("watchdog: simulation did not finish in time");
		$display("CHECKS FAILED");
		$finish;
	end

	// ========================================
	// helpers
	// ========================================
	function automatic conv_pkg::word_t next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic conv_pkg::word_t greedy_product(input conv_pkg::word_t k,
			input conv_pkg::word_t p);
		conv_pkg::word_t rem;
		conv_pkg::word_t acc;
		logic            picked;
		rem = p;
		acc = '0;
		for (int n = 0; n < MUL_TERMS; n++) begin
			picked = 1'b0;
			for (int t = 0; t < 4; t++) begin
				if (!picked && rem >= TERMS[t]) begin
					acc    = acc + k * TERMS[t];
					rem    = rem - TERMS[t];
					picked = 1'b1;
				end
			end
		end
		return acc;
	endfunction

	task automatic check_value(input string name, input conv_pkg::word_t got,
			input conv_pkg::word_t expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s: got 0x%h, expected 0x%h", name, got, expected);
		end
	endtask

	// entered 1 ns after an edge, left 1 ns after an edge
	task automatic bus_access(input logic we, input conv_pkg::waddr_t adr,
			input conv_pkg::word_t wdat, output conv_pkg::word_t rdat);
		int waited;
		waited = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = we;
		wb_adr = adr;
		wb_dat = wdat;
		@(posedge clk);
		#1;
		while (!wb_ack_o && waited < ACK_WAIT) begin
			waited++;
			@(posedge clk);
			#1;
		end
		if (!wb_ack_o) begin
			errors++;
			$display("no acknowledge for the access at address 0x%h", adr);
		end else if (waited != 0) begin
			errors++;
			$display("acknowledge for address 0x%h came %0d cycles late", adr, waited);
		end
		rdat   = wb_dat_o;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		@(posedge clk);
		#1;
		// a second ack would show up here
		check_value("wb_ack_o", {31'b0, wb_ack_o}, 32'd0);
	endtask

	task automatic wb_write(input conv_pkg::waddr_t adr, input conv_pkg::word_t dat);
		conv_pkg::word_t unused;
		bus_access(1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input conv_pkg::waddr_t adr, output conv_pkg::word_t dat);
		bus_access(1'b0, adr, '0, dat);
	endtask

	task automatic load_kernel();
		for (int i = 0; i < conv_pkg::KERNEL_N; i++) begin
			wb_write(conv_pkg::waddr_t'(i) + conv_pkg::KERNEL_BASE, kern[i]);
		end
	endtask

	task automatic load_pixels();
		for (int i = 0; i < conv_pkg::IFMAP_N; i++) begin
			wb_write(conv_pkg::waddr_t'(i) + conv_pkg::IFMAP_BASE, pix[i]);
		end
	endtask

	// reference model, output o sits at row o/2, column o%2
	task automatic compute_expected(input logic exact);
		conv_pkg::word_t p;
		int              r;
		int              c;
		exp_count = 0;
		for (int o = 0; o < conv_pkg::RESULT_N; o++) begin
			exp_res[o] = '0;
		end
		for (int i = 0; i < conv_pkg::KERNEL_N; i++) begin
			if (kern[i] != '0) begin
				exp_count++;
				r = i / 3;
				c = i % 3;
				for (int o = 0; o < conv_pkg::RESULT_N; o++) begin
					p = pix[(o / 2 + r) * 4 + (o % 2) + c];
					if (exact) begin
						exp_res[o] = exp_res[o] + kern[i] * p;
					end else begin
						exp_res[o] = exp_res[o] + greedy_product(kern[i], p);
					end
				end
			end
		end
	endtask

	task automatic wait_done();
		conv_pkg::word_t status;
		int              polls;
		polls = 0;
		do begin
			wb_read(conv_pkg::STATUS_ADDR, status);
			polls++;
		end while (!status[1] && polls < POLL_LIMIT);
		if (!status[1]) begin
			errors++;
			$display("run did not finish after %0d status polls", polls);
		end
	endtask

	task automatic run_and_wait();
		wb_write(conv_pkg::CTRL_ADDR, 32'd1);
		wait_done();
	endtask

	task automatic check_results();
		conv_pkg::word_t status;
		conv_pkg::word_t rd;
		wb_read(conv_pkg::STATUS_ADDR, status);
		check_value("status.busy", {31'b0, status[0]}, 32'd0);
		check_value("status.count", {28'b0, status[7:4]}, conv_pkg::word_t'(exp_count));
		for (int o = 0; o < conv_pkg::RESULT_N; o++) begin
			wb_read(conv_pkg::waddr_t'(o) + conv_pkg::RESULT_BASE, rd);
			check_value($sformatf("result[%0d]", o), rd, exp_res[o]);
		end
	endtask

	// ========================================
	// tests
	// ========================================
	task automatic after_reset();
		conv_pkg::word_t rd;
		wb_read(conv_pkg::STATUS_ADDR, rd);
		check_value("status", rd, 32'd0);
		for (int o = 0; o < conv_pkg::RESULT_N; o++) begin
			wb_read(conv_pkg::waddr_t'(o) + conv_pkg::RESULT_BASE, rd);
			check_value($sformatf("result[%0d]", o), rd, 32'd0);
		end
		wb_read(6'h3f, rd);
		check_value("unmapped read", rd, 32'd0);
	endtask

	task automatic dense_kernel();
		for (int i = 0; i < conv_pkg::KERNEL_N; i++) begin
			kern[i] = next_rand() | 32'd1;
		end
		// greedy split is exact for pixels below 16
		for (int i = 0; i < conv_pkg::IFMAP_N; i++) begin
			pix[i] = next_rand() % 32'd16;
		end
		load_kernel();
		load_pixels();
		compute_expected(1'b1);
		run_and_wait();
		check_results();
	endtask

	task automatic sparse_kernel();
		conv_pkg::word_t r;
		for (int i = 0; i < conv_pkg::KERNEL_N; i++) begin
			r = next_rand();
			kern[i] = r[16] ? '0 : next_rand();
		end
		for (int i = 0; i < conv_pkg::IFMAP_N; i++) begin
			pix[i] = next_rand() % 32'd22;
		end
		load_kernel();
		load_pixels();
		compute_expected(1'b0);
		run_and_wait();
		check_results();
	endtask

	task automatic zero_kernel();
		for (int i = 0; i < conv_pkg::KERNEL_N; i++) begin
			kern[i] = '0;
		end
		load_kernel();
		compute_expected(1'b0);
		run_and_wait();
		check_results();
	endtask

	task automatic wide_pixels();
		for (int i = 0; i < conv_pkg::KERNEL_N; i++) begin
			kern[i] = next_rand();
		end
		for (int i = 0; i < conv_pkg::IFMAP_N; i++) begin
			pix[i] = 32'd22 + next_rand() % 32'd1000;
		end
		pix[15] = 32'hffff_ffff;
		load_kernel();
		load_pixels();
		compute_expected(1'b0);
		run_and_wait();
		check_results();
	endtask

	task automatic busy_writes();
		conv_pkg::word_t status;
		for (int i = 0; i < conv_pkg::KERNEL_N; i++) begin
			kern[i] = next_rand() % 32'd50;
		end
		for (int i = 0; i < conv_pkg::IFMAP_N; i++) begin
			pix[i] = next_rand() % 32'd22;
		end
		load_kernel();
		load_pixels();
		compute_expected(1'b0);
		wb_write(conv_pkg::CTRL_ADDR, 32'd1);
		wb_read(conv_pkg::STATUS_ADDR, status);
		check_value("status.busy", {31'b0, status[0]}, 32'd1);
		// the scan alone takes nine cycles, these land inside it
		wb_write(conv_pkg::KERNEL_BASE, 32'h0000_1234);
		wb_write(conv_pkg::IFMAP_BASE + 6'd5, 32'h0000_0055);
		wb_write(conv_pkg::CTRL_ADDR, 32'd1);
		wait_done();
		check_results();
		// done drops on the next start, data left as it was
		wb_write(conv_pkg::CTRL_ADDR, 32'd1);
		wb_read(conv_pkg::STATUS_ADDR, status);
		check_value("status.done", {31'b0, status[1]}, 32'd0);
		wait_done();
		check_results();
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		rst_n     = 1'b0;
		wb_cyc    = 1'b0;
		wb_stb    = 1'b0;
		wb_we     = 1'b0;
		wb_adr    = '0;
		wb_dat    = '0;
		lcg_state = 32'hf57e_5fa8;
		checks    = 0;
		errors    = 0;
		exp_count = 0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		after_reset();
		dense_kernel();
		sparse_kernel();
		zero_kernel();
		wide_pixels();
		busy_writes();

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
